//--- rtl/utf_pkg.sv
package utf_pkg;

    localparam int byte_w = 8;       // Bus byte
    localparam int char_w = 32;      // Character register
    localparam int len_w = 3;        // Pointers and lengths, up to 6 bytes
    localparam int utf32_bytes = 4;

    typedef enum logic {
        mode_utf8  = 1'b0,
        mode_utf32 = 1'b1
    } mode_e;

    typedef enum logic [1:0] {
        addr_ctl    = 2'd0,
        addr_data   = 2'd1,
        addr_status = 2'd2,
        addr_len    = 2'd3
    } reg_addr_e;

    typedef struct packed {
        logic  keep_char;   // 0 resets everything
        logic  spare_hi;
        mode_e mode;
        logic  read_dir;    // Data port reads out
        logic  big_endian;
        logic  chk_range;   // Non-Unicode counts as error
        logic  spare_lo;
        logic  keep_ptrs;   // 0 rewinds the read pointers
    } ctl_t;

    localparam ctl_t ctl_reset = 8'hFE;

    typedef struct packed {
        logic in_eof;
        logic out_eof;
        logic error;
        logic nonuni;
        logic overlong;
        logic invalid;
        logic retry;
        logic ready;
    } status_t;

    localparam logic [char_w-1:0] max_unicode_end = 32'h0011_0000;
    localparam logic [char_w-1:0] nonuni_end = 32'h8000_0000;

    // Overlong windows, indexed by sequence length
    localparam logic [char_w-1:0] overlong_lo [2:6] = '{
        32'hFFFF_F000, 32'hFFFE_0000, 32'hFFC0_0000, 32'hF800_0000, 32'hF000_0000
    };
    localparam logic [char_w-1:0] overlong_hi [2:6] = '{
        32'hFFFF_F080, 32'hFFFE_0800, 32'hFFC1_0000, 32'hF820_0000, 32'hF400_0000
    };

    // Partial sequences, indexed by bytes received so far
    localparam logic [char_w-1:0] underflow_lo [1:5] = '{
        32'hFFFF_FFC0, 32'hFFFF_F800, 32'hFFFF_0000, 32'hFFE0_0000, 32'hFC00_0000
    };
    localparam logic [char_w-1:0] underflow_hi [1:5] = '{
        32'hFFFF_FFFE, 32'hFFFF_FF80, 32'hFFFF_E000, 32'hFFF8_0000, 32'hFE00_0000
    };

endpackage

//--- rtl/utf_ctrl_regs.sv
`timescale 1ns/10ps

module utf_ctrl_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  utf_pkg::reg_addr_e            address,
    input  logic                          data_write,
    input  logic [utf_pkg::byte_w-1:0]    data_in,
    input  utf_pkg::status_t              status_flags,
    input  logic [utf_pkg::len_w-1:0]     utf8_len,
    input  logic [utf_pkg::len_w-1:0]     in_count,
    input  logic                          out_eof,
    input  logic [utf_pkg::byte_w-1:0]    dout,
    output utf_pkg::ctl_t                 ctl,
    output logic                          reset_all,
    output logic                          reset_ptrs,
    output logic                          data_write_in,
    output logic                          data_read_step,
    output logic [utf_pkg::byte_w-1:0]    data_out
);

    utf_pkg::ctl_t    ctl_new;
    utf_pkg::status_t status;
    logic             ctl_write;
    logic             data_write_any;
    logic             in_eof;

    always_comb begin
        ctl_new = utf_pkg::ctl_t'(data_in);
        ctl_new.spare_hi = 1'b0;   // Spare bits read as 0
        ctl_new.spare_lo = 1'b0;
    end

    assign ctl_write = data_write && (address == utf_pkg::addr_ctl);
    assign data_write_any = data_write && (address == utf_pkg::addr_data);

    // Action bits act on the written byte, not the stored one
    assign reset_all = ctl_write && !ctl_new.keep_char;
    assign reset_ptrs = ctl_write && !ctl_new.keep_ptrs;

    assign data_write_in = data_write_any && !ctl.read_dir;
    assign data_read_step = data_write_any && ctl.read_dir;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl <= utf_pkg::ctl_reset;
        end else if (ctl_write) begin
            ctl <= ctl_new;
        end
    end

    // Input full: six UTF-8 bytes or four UTF-32 bytes
    assign in_eof = (ctl.mode == utf_pkg::mode_utf8) ? (utf8_len == 3'd6)
                                                      : (in_count == utf_pkg::utf32_bytes);

    always_comb begin
        status = status_flags;
        status.in_eof = in_eof;
        status.out_eof = out_eof;
    end

    always_comb begin
        case (address)
            utf_pkg::addr_ctl:    data_out = ctl;
            utf_pkg::addr_data:   data_out = dout;
            utf_pkg::addr_status: data_out = status;
            utf_pkg::addr_len:    data_out = {1'b0, in_count, 1'b0, utf8_len};
        endcase
    end

endmodule

//--- rtl/utf_char_reg.sv
`timescale 1ns/10ps

module utf_char_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  utf_pkg::ctl_t                 ctl,
    input  logic                          reset_all,
    input  logic                          data_write_in,
    input  logic [utf_pkg::byte_w-1:0]    data_in,
    input  logic [utf_pkg::len_w-1:0]     utf8_len,
    input  logic                          ready,
    output logic [utf_pkg::char_w-1:0]    rc,
    output logic                          empty,
    output logic [utf_pkg::len_w-1:0]     in_count,
    output logic                          retry
);

    logic [5:1]                   lead_done;     // Sequence completes with this byte
    logic [utf_pkg::char_w-1:0]   collapsed [1:5];
    logic [utf_pkg::char_w-1:0]   shifted;
    logic [utf_pkg::char_w-1:0]   merged;        // UTF-32 value with new byte
    logic                         cont_byte;

    assign cont_byte = (data_in[7:6] == 2'b10);

    // A partial value with k bytes in holds its lead ones down to bit 5k+1.
    // A zero at bit 5k means the next continuation byte is the last one.
    for (genvar k = 1; k <= 5; k++) begin : g_lead
        localparam int lo_bit = (k == 1) ? 1 : 5 * k - 5;   // Lowest bit above overlong range
        assign lead_done[k] = (&rc[31:5*k+1]) & ~rc[5*k] & (|rc[5*k-1:lo_bit]);
        assign collapsed[k] = {{(26-5*k){1'b0}}, rc[5*k-1:0], data_in[5:0]};
    end

    // Still partial, keep the ones on top
    assign shifted = (utf8_len == 3'd5) ? {4'hF, rc[21:0], data_in[5:0]}
                                        : {rc[25:0], data_in[5:0]};

    always_comb begin
        case (in_count)
            3'd1: merged = ctl.big_endian ? {16'b0, rc[7:0], data_in}
                                          : {16'b0, data_in, rc[7:0]};
            3'd2: merged = ctl.big_endian ? {8'b0, rc[15:0], data_in}
                                          : {8'b0, data_in, rc[15:0]};
            3'd3: merged = ctl.big_endian ? {rc[23:0], data_in}
                                          : {data_in, rc[23:0]};
            default: merged = {24'b0, data_in};   // First byte
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || reset_all) begin
            rc <= '0;
            empty <= 1'b1;
            in_count <= '0;
            retry <= 1'b0;
        end else if (data_write_in) begin
            if (ctl.mode == utf_pkg::mode_utf32) begin
                if (in_count >= utf_pkg::utf32_bytes) begin
                    retry <= 1'b1;   // Fifth byte
                end else begin
                    rc <= merged;
                    empty <= 1'b0;
                    in_count <= in_count + 1'b1;
                end
            end else begin
                if (empty) begin
                    // Lead byte, sign-extended
                    rc <= {{(utf_pkg::char_w-utf_pkg::byte_w){data_in[7]}}, data_in};
                    empty <= 1'b0;
                end else if (ready || !cont_byte || utf8_len > 3'd5) begin
                    retry <= 1'b1;
                end else if (lead_done[utf8_len]) begin
                    rc <= collapsed[utf8_len];   // Drop the lead ones
                end else begin
                    rc <= shifted;
                end
            end
        end
    end

endmodule

//--- rtl/utf_classify.sv
`timescale 1ns/10ps

module utf_classify (
    input  logic [utf_pkg::char_w-1:0]    rc,
    input  logic                          empty,
    input  logic                          chk_range,
    input  logic                          retry,
    output logic [utf_pkg::len_w-1:0]     utf8_len,
    output utf_pkg::status_t              status_flags
);

    logic ready;
    logic invalid;
    logic overlong;
    logic nonuni;

    // Negative values are partial sequences, sign-extended from the lead byte
    always_comb begin
        if (empty)
            utf8_len = 3'd0;
        else if (rc < 32'h0000_0080 || rc >= 32'hFFFF_FF80)
            utf8_len = 3'd1;
        else if (rc < 32'h0000_0800 || rc >= 32'hFFFF_F000)
            utf8_len = 3'd2;
        else if (rc < 32'h0001_0000 || rc >= 32'hFFFE_0000)
            utf8_len = 3'd3;
        else if (rc < 32'h0020_0000 || rc >= 32'hFFC0_0000)
            utf8_len = 3'd4;
        else if (rc < 32'h0400_0000 || rc >= 32'hF800_0000)
            utf8_len = 3'd5;
        else
            utf8_len = 3'd6;
    end

    always_comb begin
        ready = 1'b0;
        invalid = 1'b0;
        overlong = 1'b0;
        nonuni = 1'b0;
        if (!empty) begin
            if (rc < utf_pkg::max_unicode_end) begin
                ready = 1'b1;
            end else if (rc < utf_pkg::nonuni_end) begin
                ready = 1'b1;
                nonuni = 1'b1;
            end else begin
                ready = 1'b1;
                invalid = 1'b1;   // Unless a window below claims it
                for (int n = 2; n <= 6; n++) begin
                    if (rc >= utf_pkg::overlong_lo[n] && rc < utf_pkg::overlong_hi[n]) begin
                        invalid = 1'b0;
                        overlong = 1'b1;
                    end
                end
                for (int n = 1; n <= 5; n++) begin
                    if (rc >= utf_pkg::underflow_lo[n] && rc < utf_pkg::underflow_hi[n]) begin
                        ready = 1'b0;   // Waiting for more bytes
                        invalid = 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        status_flags = '0;   // eof bits filled in by the register block
        status_flags.ready = ready;
        status_flags.invalid = invalid;
        status_flags.overlong = overlong;
        status_flags.nonuni = nonuni;
        status_flags.retry = retry;
        status_flags.error = retry | invalid | overlong | (nonuni & chk_range);
    end

endmodule

//--- rtl/utf_read_port.sv
`timescale 1ns/10ps

module utf_read_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  utf_pkg::ctl_t                 ctl,
    input  logic                          reset_all,
    input  logic                          reset_ptrs,
    input  logic                          data_read_step,
    input  logic [utf_pkg::char_w-1:0]    rc,
    input  logic [utf_pkg::len_w-1:0]     utf8_len,
    output logic [utf_pkg::byte_w-1:0]    dout,
    output logic                          out_eof
);

    logic [utf_pkg::len_w-1:0]   ptr8;     // UTF-8 bytes emitted
    logic [utf_pkg::len_w-1:0]   ptr32;    // UTF-32 bytes emitted
    logic [utf_pkg::len_w-1:0]   remain;
    logic [utf_pkg::byte_w-1:0]  byte8;
    logic [utf_pkg::byte_w-1:0]  byte32;
    logic                        done8;
    logic                        done32;

    assign remain = utf8_len - ptr8;
    assign done8 = (ptr8 >= utf8_len);
    assign done32 = (ptr32 >= utf_pkg::utf32_bytes);

    always_comb begin
        byte8 = '0;
        if (!done8) begin
            if (ptr8 == '0) begin
                // Lead byte; a partial value gives its own lead back
                case (utf8_len)
                    3'd1: byte8 = rc[7:0];
                    3'd2: byte8 = {2'b11, rc[11:6]};
                    3'd3: byte8 = {3'b111, rc[16:12]};
                    3'd4: byte8 = {4'b1111, rc[21:18]};
                    3'd5: byte8 = {5'b11111, rc[26:24]};
                    default: byte8 = {7'b1111110, rc[30] & ~rc[31]};
                endcase
            end else if (remain == 3'd5) begin
                byte8 = {2'b10, rc[29:28] & {2{~rc[31]}}, rc[27:24]};
            end else begin
                byte8 = {2'b10, rc[6*remain-1 -: 6]};   // Six bits per trailing byte
            end
        end
    end

    always_comb begin
        if (done32)
            byte32 = '0;
        else if (ctl.big_endian)
            byte32 = rc[utf_pkg::char_w-1-8*ptr32 -: 8];
        else
            byte32 = rc[8*ptr32 +: 8];
    end

    always_ff @(posedge clk) begin
        if (!rst_n || reset_all || reset_ptrs) begin
            ptr8 <= '0;
            ptr32 <= '0;
            dout <= '0;
        end else if (data_read_step) begin
            if (ctl.mode == utf_pkg::mode_utf8) begin
                dout <= byte8;
                if (!done8)
                    ptr8 <= ptr8 + 1'b1;
            end else begin
                dout <= byte32;
                if (!done32)
                    ptr32 <= ptr32 + 1'b1;
            end
        end
    end

    assign out_eof = (ctl.mode == utf_pkg::mode_utf8) ? done8 : done32;

endmodule

//--- rtl/utf_codec_top.sv
`timescale 1ns/10ps

module utf_codec_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  address,
    input  logic        data_write,   // One-cycle strobe
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out
);

    utf_pkg::ctl_t                ctl;
    utf_pkg::status_t             status_flags;
    logic                         reset_all;
    logic                         reset_ptrs;
    logic                         data_write_in;
    logic                         data_read_step;
    logic [utf_pkg::char_w-1:0]   rc;
    logic                         empty;
    logic [utf_pkg::len_w-1:0]    in_count;
    logic                         retry;
    logic [utf_pkg::len_w-1:0]    utf8_len;
    logic [utf_pkg::byte_w-1:0]   dout;
    logic                         out_eof;

    utf_ctrl_regs u_ctrl_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (utf_pkg::reg_addr_e'(address)),
        .data_write     (data_write),
        .data_in        (data_in),
        .status_flags   (status_flags),
        .utf8_len       (utf8_len),
        .in_count       (in_count),
        .out_eof        (out_eof),
        .dout           (dout),
        .ctl            (ctl),
        .reset_all      (reset_all),
        .reset_ptrs     (reset_ptrs),
        .data_write_in  (data_write_in),
        .data_read_step (data_read_step),
        .data_out       (data_out)
    );

    utf_char_reg u_char_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctl           (ctl),
        .reset_all     (reset_all),
        .data_write_in (data_write_in),
        .data_in       (data_in),
        .utf8_len      (utf8_len),
        .ready         (status_flags.ready),
        .rc            (rc),
        .empty         (empty),
        .in_count      (in_count),
        .retry         (retry)
    );

    utf_classify u_classify (
        .rc           (rc),
        .empty        (empty),
        .chk_range    (ctl.chk_range),
        .retry        (retry),
        .utf8_len     (utf8_len),
        .status_flags (status_flags)
    );

    utf_read_port u_read_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctl            (ctl),
        .reset_all      (reset_all),
        .reset_ptrs     (reset_ptrs),
        .data_read_step (data_read_step),
        .rc             (rc),
        .utf8_len       (utf8_len),
        .dout           (dout),
        .out_eof        (out_eof)
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam time half_period = 5ns;   // 10 ns clock

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- dv/tb_utf_codec.sv
`timescale 1ns/10ps

module tb_utf_codec;

    localparam int n_rand = 50;           // Per random conversion test
    localparam int n_small = 10;          // Per flag test
    localparam int total_trans = 2 + 2 * n_rand + 2 * n_small;
    localparam int cycles_per_trans = 200;

    logic        clk;
    logic        rst_n;
    logic [1:0]  address;
    logic        data_write;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [31:0] lcg_state;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    utf_codec_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out)
    );

    // Two LCG steps, high halves only
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] rand_below(input logic [31:0] limit);
        return next_rand() % limit;
    endfunction

    function automatic logic [7:0] ctl_byte(input logic keep_char, input utf_pkg::mode_e mode,
                                            input logic read_dir, input logic be,
                                            input logic chk, input logic keep_ptrs);
        return {keep_char, 1'b0, mode, read_dir, be, chk, 1'b0, keep_ptrs};
    endfunction

    function automatic logic [7:0] status_byte(input logic in_eof, input logic out_eof,
                                               input logic error, input logic nonuni,
                                               input logic overlong, input logic invalid,
                                               input logic retry, input logic ready);
        return {in_eof, out_eof, error, nonuni, overlong, invalid, retry, ready};
    endfunction

    function automatic logic [7:0] len_byte(input int in_cnt, input int len8);
        return {1'b0, 3'(in_cnt), 1'b0, 3'(len8)};
    endfunction

    function automatic int utf8_length(input logic [31:0] cp);
        if (cp < 32'h80)
            return 1;
        if (cp < 32'h800)
            return 2;
        if (cp < 32'h1_0000)
            return 3;
        return 4;
    endfunction

    // Standard UTF-8 encoding, byte idx of the sequence
    function automatic logic [7:0] utf8_byte(input logic [31:0] cp, input int idx);
        int          len;
        logic [31:0] part;
        logic [7:0]  lead_ones;
        len = utf8_length(cp);
        part = cp >> (6 * (len - 1 - idx));
        if (len == 1)
            return cp[7:0];
        if (idx == 0) begin
            lead_ones = 8'hFF << (8 - len);
            return lead_ones | part[7:0];
        end
        return {2'b10, part[5:0]};
    endfunction

    function automatic logic [7:0] byte_of(input logic [31:0] value, input int idx,
                                           input logic be);
        logic [31:0] shifted;
        shifted = be ? value >> (24 - 8 * idx) : value >> (8 * idx);
        return shifted[7:0];
    endfunction

    // Even spread over the four sequence lengths
    function automatic logic [31:0] pick_utf8_cp();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0: return r[31:2] % 32'h80;
            2'd1: return 32'h80 + r[31:2] % 32'h780;
            2'd2: return 32'h800 + r[31:2] % 32'hF800;
            default: return 32'h1_0000 + r[31:2] % 32'h10_0000;
        endcase
    endfunction

    task automatic report_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped on failure");
    endtask

    task automatic write_reg(input utf_pkg::reg_addr_e addr, input logic [7:0] value);
        @(negedge clk);
        address = addr;
        data_in = value;
        data_write = 1'b1;
        @(negedge clk);
        data_write = 1'b0;
    endtask

    task automatic read_reg(input utf_pkg::reg_addr_e addr, output logic [7:0] value);
        @(negedge clk);
        address = addr;
        #1;   // Settled, well before the next rising edge
        value = data_out;
    endtask

    task automatic expect_reg(input utf_pkg::reg_addr_e addr, input logic [7:0] expected,
                              input string name);
        logic [7:0] got;
        read_reg(addr, got);
        assert (got === expected) else begin
            $display("ERR at %0t: %s is 8'h%02h, expected 8'h%02h",
                     $time, name, got, expected);
            report_failure();
        end
    endtask

    task automatic read_step(input logic [7:0] expected, input string name);
        write_reg(utf_pkg::addr_data, 8'h00);
        expect_reg(utf_pkg::addr_data, expected, name);
    endtask

    // Readback of the whole word, then one byte past the end
    task automatic read_utf32(input logic [31:0] cp, input logic be,
                              input logic [7:0] final_status);
        write_reg(utf_pkg::addr_ctl, ctl_byte(1, utf_pkg::mode_utf32, 1, be, 1, 0));
        for (int i = 0; i < 4; i++)
            read_step(byte_of(cp, i, be), $sformatf("data_out utf32 byte %0d", i));
        expect_reg(utf_pkg::addr_status, final_status, "status after utf32 read");
        read_step(8'h00, "data_out past utf32 end");
    endtask

    task automatic utf32_in_utf8_out();
        logic [31:0] cp;
        logic        be;
        int          len;
        cp = rand_below(utf_pkg::max_unicode_end);
        be = next_rand() >> 31;
        len = utf8_length(cp);
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf32, 0, be, 1, 0));
        for (int i = 0; i < 4; i++) begin
            write_reg(utf_pkg::addr_data, byte_of(cp, i, be));
            expect_reg(utf_pkg::addr_status, status_byte(i == 3, 0, 0, 0, 0, 0, 0, 1),
                       $sformatf("status after utf32 byte %0d", i));
        end
        expect_reg(utf_pkg::addr_len, len_byte(4, len), "length byte");
        write_reg(utf_pkg::addr_ctl, ctl_byte(1, utf_pkg::mode_utf8, 1, be, 1, 0));
        expect_reg(utf_pkg::addr_status, 8'h01, "status before utf8 read");
        for (int i = 0; i < len; i++)
            read_step(utf8_byte(cp, i), $sformatf("data_out utf8 byte %0d", i));
        expect_reg(utf_pkg::addr_status, status_byte(0, 1, 0, 0, 0, 0, 0, 1),
                   "status after utf8 read");
        read_step(8'h00, "data_out past utf8 end");
    endtask

    task automatic utf8_in_utf32_out();
        logic [31:0] cp;
        int          len;
        cp = pick_utf8_cp();
        len = utf8_length(cp);
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf8, 0, 0, 1, 0));
        for (int i = 0; i < len; i++) begin
            write_reg(utf_pkg::addr_data, utf8_byte(cp, i));
            // Ready only once the last byte is in
            expect_reg(utf_pkg::addr_status, status_byte(0, 0, 0, 0, 0, 0, 0, i == len - 1),
                       $sformatf("status after utf8 byte %0d", i));
            expect_reg(utf_pkg::addr_len, len_byte(0, i + 1),
                       $sformatf("length byte after utf8 byte %0d", i));
        end
        read_utf32(cp, 1'b0, status_byte(0, 1, 0, 0, 0, 0, 0, 1));
        read_utf32(cp, 1'b1, status_byte(0, 1, 0, 0, 0, 0, 0, 1));
    endtask

    task automatic overlong_input();
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf8, 0, 0, 1, 0));
        write_reg(utf_pkg::addr_data, 8'hC0);
        expect_reg(utf_pkg::addr_status, 8'h00, "status after C0");
        write_reg(utf_pkg::addr_data, 8'h80);
        expect_reg(utf_pkg::addr_status, status_byte(0, 0, 1, 0, 1, 0, 0, 1),
                   "status after C0 80");
    endtask

    task automatic bad_continuation();
        logic [31:0] cp;
        logic [7:0]  bad;
        cp = 32'h80 + rand_below(32'h780);
        bad = next_rand() >> 24;
        if (bad[7:6] == 2'b10)
            bad[7] = 1'b0;   // Anything but 10xxxxxx
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf8, 0, 0, 1, 0));
        write_reg(utf_pkg::addr_data, utf8_byte(cp, 0));
        write_reg(utf_pkg::addr_data, bad);
        expect_reg(utf_pkg::addr_status, status_byte(0, 0, 1, 0, 0, 0, 1, 0),
                   "status after bad byte");
        write_reg(utf_pkg::addr_data, utf8_byte(cp, 1));
        expect_reg(utf_pkg::addr_status, status_byte(0, 0, 1, 0, 0, 0, 1, 1),
                   "status after retry");
        // Value untouched by the rejected byte
        read_utf32(cp, 1'b1, status_byte(0, 1, 1, 0, 0, 0, 1, 1));
    endtask

    task automatic range_flag();
        logic [31:0] cp;
        cp = utf_pkg::max_unicode_end
             + rand_below(utf_pkg::nonuni_end - utf_pkg::max_unicode_end);
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf32, 0, 1, 1, 0));
        for (int i = 0; i < 4; i++)
            write_reg(utf_pkg::addr_data, byte_of(cp, i, 1'b1));
        expect_reg(utf_pkg::addr_status, status_byte(1, 0, 1, 1, 0, 0, 0, 1),
                   "status nonuni with range check");
        write_reg(utf_pkg::addr_ctl, ctl_byte(1, utf_pkg::mode_utf32, 0, 1, 0, 1));
        expect_reg(utf_pkg::addr_status, status_byte(1, 0, 0, 1, 0, 0, 0, 1),
                   "status nonuni without range check");
        write_reg(utf_pkg::addr_ctl, ctl_byte(0, utf_pkg::mode_utf32, 0, 1, 1, 1));
        expect_reg(utf_pkg::addr_status, 8'h00, "status after reset all");
    endtask

    initial begin
        repeat (cycles_per_trans * total_trans) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles",
                 cycles_per_trans * total_trans);
        report_failure();
    end

    initial begin
        address = 2'd0;
        data_write = 1'b0;
        data_in = 8'h00;
        lcg_state = 32'h9248_8f19;
        wait (rst_n === 1'b1);
        expect_reg(utf_pkg::addr_ctl, 8'hFE, "ctl after reset");
        expect_reg(utf_pkg::addr_status, 8'h00, "status after reset");
        repeat (n_rand) utf32_in_utf8_out();
        repeat (n_rand) utf8_in_utf32_out();
        overlong_input();
        repeat (n_small) bad_continuation();
        repeat (n_small) range_flag();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
rtl/utf_pkg.sv
rtl/utf_ctrl_regs.sv
rtl/utf_char_reg.sv
rtl/utf_classify.sv
rtl/utf_read_port.sv
rtl/utf_codec_top.sv
dv/tb_clock.sv
dv/tb_utf_codec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_utf_codec
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard rtl/*.sv dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
